/* src/decode_defs.svh */
`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

// bundle geometry
`define DEC_ISSUE_W 4
`define DEC_INST_W 16

// opcodes in bits 15:12
`define OP_NOP 4'h0
`define OP_ADD 4'h1
`define OP_SUB 4'h2
`define OP_MUL 4'h3
`define OP_AND 4'h4
`define OP_OR 4'h5
`define OP_ADDI 4'h6
`define OP_LDI 4'h7
`define OP_LD 4'h8
`define OP_ST 4'h9
`define OP_BEQ 4'ha
`define OP_BNE 4'hb
`define OP_JMP 4'hc
// 4'hd to 4'hf undefined

// alu operations
`define ALU_ADD 3'd0
`define ALU_SUB 3'd1
`define ALU_MUL 3'd2
`define ALU_AND 3'd3
`define ALU_OR 3'd4
`define ALU_PASS 3'd5

// execution units
`define UNIT_ADD 2'd0
`define UNIT_MULT 2'd1
`define UNIT_ADDR 2'd2

// immediate source
`define IMM_ZERO 2'd0
`define IMM_RT4 2'd1
`define IMM_LOW8 2'd2
`define IMM_TARGET 2'd3

`endif

/* src/decode_pkg.sv */
`default_nettype none

`include "decode_defs.svh"

package decode_pkg;

	// one instruction: opcode 15:12, rd 11:8, rs 7:4, rt 3:0
	typedef logic [`DEC_INST_W-1:0] inst_t;

	// slot 0 in the top bits
	typedef logic [`DEC_ISSUE_W*`DEC_INST_W-1:0] bundle_t;

	typedef logic [15:0] pc_t;
	typedef logic [`DEC_ISSUE_W*16-1:0] pc_bundle_t;

	typedef logic [3:0] reg_idx_t;
	typedef logic [2:0] alu_op_t;
	typedef logic [1:0] unit_t;

	// valid, unit, alu_op, reg_write, mem_read, mem_write,
	// is_branch, is_jump, pred_taken, rd, rs, rt, imm
	typedef logic [39:0] dec_word_t;

	typedef enum logic [1:0] {
		LT_IDLE = 2'd0,
		LT_SEEN = 2'd1,
		LT_LOCKED = 2'd2
	} loop_state_t;

endpackage

`default_nettype wire

/* src/slot_ctrl_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "decode_defs.svh"

module slot_ctrl_decode (
	input wire [3:0] opcode,
	output logic ctl_valid,
	output decode_pkg::unit_t unit,
	output decode_pkg::alu_op_t alu_op,
	output logic reg_write,
	output logic mem_read,
	output logic mem_write,
	output logic is_branch,
	output logic is_jump,
	output logic rd_used,
	output logic rs_used,
	output logic rt_used,
	output logic [1:0] imm_sel
);

	always_comb begin
		ctl_valid = 1'b1;
		unit = `UNIT_ADD;
		alu_op = `ALU_ADD;
		reg_write = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		is_branch = 1'b0;
		is_jump = 1'b0;
		rd_used = 1'b0;
		rs_used = 1'b0;
		rt_used = 1'b0;
		imm_sel = `IMM_ZERO;
		case (opcode)
			// register-register ops
			`OP_ADD, `OP_SUB, `OP_MUL, `OP_AND, `OP_OR: begin
				reg_write = 1'b1;
				rd_used = 1'b1;
				rs_used = 1'b1;
				rt_used = 1'b1;
				case (opcode)
					`OP_SUB: alu_op = `ALU_SUB;
					`OP_AND: alu_op = `ALU_AND;
					`OP_OR: alu_op = `ALU_OR;
					`OP_MUL: begin
						unit = `UNIT_MULT;
						alu_op = `ALU_MUL;
					end
					default: alu_op = `ALU_ADD;
				endcase
			end
			`OP_ADDI: begin
				reg_write = 1'b1;
				rd_used = 1'b1;
				rs_used = 1'b1;
				imm_sel = `IMM_RT4;
			end
			// load immediate passes the sign-extended low byte
			`OP_LDI: begin
				alu_op = `ALU_PASS;
				reg_write = 1'b1;
				rd_used = 1'b1;
				imm_sel = `IMM_LOW8;
			end
			`OP_LD: begin
				unit = `UNIT_ADDR;
				reg_write = 1'b1;
				mem_read = 1'b1;
				rd_used = 1'b1;
				rs_used = 1'b1;
				imm_sel = `IMM_RT4;
			end
			`OP_ST: begin
				unit = `UNIT_ADDR;
				mem_write = 1'b1;
				rs_used = 1'b1;
				rt_used = 1'b1;
			end
			// compare by subtraction
			`OP_BEQ, `OP_BNE: begin
				alu_op = `ALU_SUB;
				is_branch = 1'b1;
				rs_used = 1'b1;
				rt_used = 1'b1;
				imm_sel = `IMM_TARGET;
			end
			`OP_JMP: begin
				alu_op = `ALU_PASS;
				is_jump = 1'b1;
				imm_sel = `IMM_TARGET;
			end
			`OP_NOP: ctl_valid = 1'b0;
			// undefined opcodes
			default: ctl_valid = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

/* src/field_split_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "decode_defs.svh"

module field_split_stage (
	input wire clk,
	input wire reset,
	input wire flush,
	input wire decode_pkg::bundle_t fetch_bundle,
	input wire decode_pkg::pc_bundle_t fetch_pc,
	input wire decode_pkg::pc_bundle_t fetch_target,
	input wire [`DEC_ISSUE_W-1:0] fetch_pred,
	input wire fetch_valid,
	output decode_pkg::unit_t [`DEC_ISSUE_W-1:0] s1_unit,
	output decode_pkg::alu_op_t [`DEC_ISSUE_W-1:0] s1_alu_op,
	output logic [`DEC_ISSUE_W-1:0] s1_reg_write,
	output logic [`DEC_ISSUE_W-1:0] s1_mem_read,
	output logic [`DEC_ISSUE_W-1:0] s1_mem_write,
	output logic [`DEC_ISSUE_W-1:0] s1_is_branch,
	output logic [`DEC_ISSUE_W-1:0] s1_is_jump,
	output logic [`DEC_ISSUE_W-1:0] s1_rd_used,
	output logic [`DEC_ISSUE_W-1:0] s1_rs_used,
	output logic [`DEC_ISSUE_W-1:0] s1_rt_used,
	output logic [`DEC_ISSUE_W-1:0][1:0] s1_imm_sel,
	output decode_pkg::bundle_t s1_inst,
	output decode_pkg::pc_bundle_t s1_pc,
	output decode_pkg::pc_bundle_t s1_target,
	output logic [`DEC_ISSUE_W-1:0] s1_pred,
	output logic [`DEC_ISSUE_W-1:0] s1_valid
);

	import decode_pkg::*;

	// index b holds slot ISSUE_W-1-b, so slot 0 sits in the top bits
	logic [`DEC_ISSUE_W-1:0] ctl_valid;
	unit_t [`DEC_ISSUE_W-1:0] ctl_unit;
	alu_op_t [`DEC_ISSUE_W-1:0] ctl_alu_op;
	logic [`DEC_ISSUE_W-1:0] ctl_reg_write;
	logic [`DEC_ISSUE_W-1:0] ctl_mem_read;
	logic [`DEC_ISSUE_W-1:0] ctl_mem_write;
	logic [`DEC_ISSUE_W-1:0] ctl_is_branch;
	logic [`DEC_ISSUE_W-1:0] ctl_is_jump;
	logic [`DEC_ISSUE_W-1:0] ctl_rd_used;
	logic [`DEC_ISSUE_W-1:0] ctl_rs_used;
	logic [`DEC_ISSUE_W-1:0] ctl_rt_used;
	logic [`DEC_ISSUE_W-1:0][1:0] ctl_imm_sel;

	genvar b;
	generate
		for (b = 0; b < `DEC_ISSUE_W; b++) begin : g_slot
			inst_t slot_inst;

			assign slot_inst = fetch_bundle[b*`DEC_INST_W +: `DEC_INST_W];

			slot_ctrl_decode i_ctrl (
				.opcode(slot_inst[15:12]),
				.ctl_valid(ctl_valid[b]),
				.unit(ctl_unit[b]),
				.alu_op(ctl_alu_op[b]),
				.reg_write(ctl_reg_write[b]),
				.mem_read(ctl_mem_read[b]),
				.mem_write(ctl_mem_write[b]),
				.is_branch(ctl_is_branch[b]),
				.is_jump(ctl_is_jump[b]),
				.rd_used(ctl_rd_used[b]),
				.rs_used(ctl_rs_used[b]),
				.rt_used(ctl_rt_used[b]),
				.imm_sel(ctl_imm_sel[b])
			);
		end
	endgenerate

	// nop and undefined opcodes drop out here
	always_ff @(posedge clk) begin
		if (reset || flush)
			s1_valid <= '0;
		else
			s1_valid <= {`DEC_ISSUE_W{fetch_valid}} & ctl_valid;
	end

	always_ff @(posedge clk) begin
		s1_inst <= fetch_bundle;
		s1_pc <= fetch_pc;
		s1_target <= fetch_target;
		s1_pred <= fetch_pred;
		s1_unit <= ctl_unit;
		s1_alu_op <= ctl_alu_op;
		s1_reg_write <= ctl_reg_write;
		s1_mem_read <= ctl_mem_read;
		s1_mem_write <= ctl_mem_write;
		s1_is_branch <= ctl_is_branch;
		s1_is_jump <= ctl_is_jump;
		s1_rd_used <= ctl_rd_used;
		s1_rs_used <= ctl_rs_used;
		s1_rt_used <= ctl_rt_used;
		s1_imm_sel <= ctl_imm_sel;
	end

endmodule

`default_nettype wire

/* src/operand_format_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "decode_defs.svh"

module operand_format_stage (
	input wire clk,
	input wire reset,
	input wire flush,
	input wire decode_pkg::unit_t [`DEC_ISSUE_W-1:0] s1_unit,
	input wire decode_pkg::alu_op_t [`DEC_ISSUE_W-1:0] s1_alu_op,
	input wire [`DEC_ISSUE_W-1:0] s1_reg_write,
	input wire [`DEC_ISSUE_W-1:0] s1_mem_read,
	input wire [`DEC_ISSUE_W-1:0] s1_mem_write,
	input wire [`DEC_ISSUE_W-1:0] s1_is_branch,
	input wire [`DEC_ISSUE_W-1:0] s1_is_jump,
	input wire [`DEC_ISSUE_W-1:0] s1_rd_used,
	input wire [`DEC_ISSUE_W-1:0] s1_rs_used,
	input wire [`DEC_ISSUE_W-1:0] s1_rt_used,
	input wire [`DEC_ISSUE_W-1:0][1:0] s1_imm_sel,
	input wire decode_pkg::bundle_t s1_inst,
	input wire decode_pkg::pc_bundle_t s1_pc,
	input wire decode_pkg::pc_bundle_t s1_target,
	input wire [`DEC_ISSUE_W-1:0] s1_pred,
	input wire [`DEC_ISSUE_W-1:0] s1_valid,
	output decode_pkg::dec_word_t dec_word0,
	output decode_pkg::dec_word_t dec_word1,
	output decode_pkg::dec_word_t dec_word2,
	output decode_pkg::dec_word_t dec_word3,
	output logic [`DEC_ISSUE_W-1:0] back_loop,
	output decode_pkg::pc_bundle_t loop_target
);

	import decode_pkg::*;

	// everything below the valid bit
	localparam int BODY_W = $bits(dec_word_t) - 1;

	logic [`DEC_ISSUE_W-1:0] pred_taken;
	logic [`DEC_ISSUE_W-1:0] back_next;
	logic [`DEC_ISSUE_W-1:0][BODY_W-1:0] body_next;
	logic [`DEC_ISSUE_W-1:0][BODY_W-1:0] body_q;
	logic [`DEC_ISSUE_W-1:0] valid_q;

	genvar b;
	generate
		for (b = 0; b < `DEC_ISSUE_W; b++) begin : g_slot
			inst_t inst;
			pc_t pc;
			pc_t target;
			reg_idx_t rd;
			reg_idx_t rs;
			reg_idx_t rt;
			logic [15:0] imm;

			assign inst = s1_inst[b*`DEC_INST_W +: `DEC_INST_W];
			assign pc = s1_pc[b*16 +: 16];
			assign target = s1_target[b*16 +: 16];

			// unused register fields read as zero
			assign rd = s1_rd_used[b] ? inst[11:8] : '0;
			assign rs = s1_rs_used[b] ? inst[7:4] : '0;
			assign rt = s1_rt_used[b] ? inst[3:0] : '0;

			always_comb begin
				case (s1_imm_sel[b])
					`IMM_RT4: imm = {{12{inst[3]}}, inst[3:0]};
					`IMM_LOW8: imm = {{8{inst[7]}}, inst[7:0]};
					`IMM_TARGET: imm = target;
					default: imm = '0;
				endcase
			end

			// jumps are always taken
			assign pred_taken[b] = s1_is_branch[b] ? s1_pred[b] : s1_is_jump[b];

			// taken transfer to a target at or below its own pc
			assign back_next[b] = s1_valid[b] && pred_taken[b] && (target <= pc);

			assign body_next[b] = {s1_unit[b], s1_alu_op[b],
				s1_reg_write[b], s1_mem_read[b], s1_mem_write[b],
				s1_is_branch[b], s1_is_jump[b], pred_taken[b],
				rd, rs, rt, imm};
		end
	endgenerate

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			valid_q <= '0;
			back_loop <= '0;
		end else begin
			valid_q <= s1_valid;
			back_loop <= back_next;
		end
	end

	always_ff @(posedge clk) begin
		body_q <= body_next;
		loop_target <= s1_target;
	end

	// an invalid slot shows an all-zero word
	assign dec_word0 = valid_q[3] ? {1'b1, body_q[3]} : '0;
	assign dec_word1 = valid_q[2] ? {1'b1, body_q[2]} : '0;
	assign dec_word2 = valid_q[1] ? {1'b1, body_q[1]} : '0;
	assign dec_word3 = valid_q[0] ? {1'b1, body_q[0]} : '0;

endmodule

`default_nettype wire

/* src/loop_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "decode_defs.svh"

module loop_tracker (
	input wire clk,
	input wire reset,
	input wire mispredict,
	input wire [`DEC_ISSUE_W-1:0] back_loop,
	input wire decode_pkg::pc_bundle_t loop_target,
	output decode_pkg::loop_state_t loop_state,
	output logic loop_start,
	output logic stall_fetch
);

	import decode_pkg::*;

	loop_state_t state_q;
	loop_state_t state_next;
	pc_t target_q;
	pc_t flag_target;
	logic flag_hit;
	logic record;
	logic start_next;

	// lowest-numbered slot wins; slot 0 is the top bit, visited last
	always_comb begin
		flag_target = '0;
		for (int i = 0; i < `DEC_ISSUE_W; i++) begin
			if (back_loop[i])
				flag_target = loop_target[i*16 +: 16];
		end
	end

	assign flag_hit = |back_loop;

	always_comb begin
		state_next = state_q;
		record = 1'b0;
		start_next = 1'b0;
		case (state_q)
			LT_IDLE: begin
				if (flag_hit) begin
					state_next = LT_SEEN;
					record = 1'b1;
				end
			end
			LT_SEEN: begin
				if (flag_hit && flag_target == target_q) begin
					state_next = LT_LOCKED;
					start_next = 1'b1;
				end else if (flag_hit) begin
					// different loop, follow the new target
					record = 1'b1;
				end
			end
			// locked until the flush
			LT_LOCKED: state_next = LT_LOCKED;
			default: state_next = LT_IDLE;
		endcase
		if (mispredict) begin
			state_next = LT_IDLE;
			record = 1'b0;
			start_next = 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q <= LT_IDLE;
			loop_start <= 1'b0;
		end else begin
			state_q <= state_next;
			loop_start <= start_next;
		end
	end

	always_ff @(posedge clk) begin
		if (record)
			target_q <= flag_target;
	end

	assign loop_state = state_q;
	assign stall_fetch = (state_q == LT_LOCKED);

endmodule

`default_nettype wire

/* src/decode_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "decode_defs.svh"

module decode_top (
	input wire clk,
	input wire reset,
	input wire decode_pkg::bundle_t fetch_bundle,
	input wire decode_pkg::pc_bundle_t fetch_pc,
	input wire decode_pkg::pc_bundle_t fetch_target,
	input wire [`DEC_ISSUE_W-1:0] fetch_pred,
	input wire fetch_valid,
	input wire mispredict,
	output decode_pkg::dec_word_t dec_word0,
	output decode_pkg::dec_word_t dec_word1,
	output decode_pkg::dec_word_t dec_word2,
	output decode_pkg::dec_word_t dec_word3,
	output decode_pkg::loop_state_t loop_state,
	output logic loop_start,
	output logic stall_fetch
);

	import decode_pkg::*;

	// step 1 to step 2
	unit_t [`DEC_ISSUE_W-1:0] s1_unit;
	alu_op_t [`DEC_ISSUE_W-1:0] s1_alu_op;
	logic [`DEC_ISSUE_W-1:0] s1_reg_write;
	logic [`DEC_ISSUE_W-1:0] s1_mem_read;
	logic [`DEC_ISSUE_W-1:0] s1_mem_write;
	logic [`DEC_ISSUE_W-1:0] s1_is_branch;
	logic [`DEC_ISSUE_W-1:0] s1_is_jump;
	logic [`DEC_ISSUE_W-1:0] s1_rd_used;
	logic [`DEC_ISSUE_W-1:0] s1_rs_used;
	logic [`DEC_ISSUE_W-1:0] s1_rt_used;
	logic [`DEC_ISSUE_W-1:0][1:0] s1_imm_sel;
	bundle_t s1_inst;
	pc_bundle_t s1_pc;
	pc_bundle_t s1_target;
	logic [`DEC_ISSUE_W-1:0] s1_pred;
	logic [`DEC_ISSUE_W-1:0] s1_valid;

	// step 2 to tracker
	logic [`DEC_ISSUE_W-1:0] back_loop;
	pc_bundle_t loop_target;

	field_split_stage i_field_split (
		.clk(clk),
		.reset(reset),
		.flush(mispredict),
		.fetch_bundle(fetch_bundle),
		.fetch_pc(fetch_pc),
		.fetch_target(fetch_target),
		.fetch_pred(fetch_pred),
		.fetch_valid(fetch_valid),
		.s1_unit(s1_unit),
		.s1_alu_op(s1_alu_op),
		.s1_reg_write(s1_reg_write),
		.s1_mem_read(s1_mem_read),
		.s1_mem_write(s1_mem_write),
		.s1_is_branch(s1_is_branch),
		.s1_is_jump(s1_is_jump),
		.s1_rd_used(s1_rd_used),
		.s1_rs_used(s1_rs_used),
		.s1_rt_used(s1_rt_used),
		.s1_imm_sel(s1_imm_sel),
		.s1_inst(s1_inst),
		.s1_pc(s1_pc),
		.s1_target(s1_target),
		.s1_pred(s1_pred),
		.s1_valid(s1_valid)
	);

	operand_format_stage i_operand_format (
		.clk(clk),
		.reset(reset),
		.flush(mispredict),
		.s1_unit(s1_unit),
		.s1_alu_op(s1_alu_op),
		.s1_reg_write(s1_reg_write),
		.s1_mem_read(s1_mem_read),
		.s1_mem_write(s1_mem_write),
		.s1_is_branch(s1_is_branch),
		.s1_is_jump(s1_is_jump),
		.s1_rd_used(s1_rd_used),
		.s1_rs_used(s1_rs_used),
		.s1_rt_used(s1_rt_used),
		.s1_imm_sel(s1_imm_sel),
		.s1_inst(s1_inst),
		.s1_pc(s1_pc),
		.s1_target(s1_target),
		.s1_pred(s1_pred),
		.s1_valid(s1_valid),
		.dec_word0(dec_word0),
		.dec_word1(dec_word1),
		.dec_word2(dec_word2),
		.dec_word3(dec_word3),
		.back_loop(back_loop),
		.loop_target(loop_target)
	);

	loop_tracker i_loop_tracker (
		.clk(clk),
		.reset(reset),
		.mispredict(mispredict),
		.back_loop(back_loop),
		.loop_target(loop_target),
		.loop_state(loop_state),
		.loop_start(loop_start),
		.stall_fetch(stall_fetch)
	);

endmodule

`default_nettype wire

/* bench/tb_decode_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "decode_defs.svh"

module tb_decode_top;

	import decode_pkg::*;

	logic clk;
	logic reset;
	bundle_t fetch_bundle;
	pc_bundle_t fetch_pc;
	pc_bundle_t fetch_target;
	logic [3:0] fetch_pred;
	logic fetch_valid;
	logic mispredict;
	dec_word_t dec_word0;
	dec_word_t dec_word1;
	dec_word_t dec_word2;
	dec_word_t dec_word3;
	loop_state_t loop_state;
	logic loop_start;
	logic stall_fetch;

	// stimulus table, one entry per bundle
	string row_name[$];
	bundle_t row_bundle[$];
	pc_bundle_t row_pc[$];
	pc_bundle_t row_target[$];
	logic [3:0] row_pred[$];
	logic row_valid[$];
	logic row_mp[$];

	// expected values, four words per row
	dec_word_t exp_word[$];
	loop_state_t exp_state[$];
	logic exp_start[$];

	// slots of the row under construction
	inst_t new_inst[4];
	pc_t new_pc[4];
	pc_t new_tgt[4];

	int checks;
	int word_errors;
	int state_errors;
	int bit_errors;

	decode_top i_decode_top (
		.clk(clk),
		.reset(reset),
		.fetch_bundle(fetch_bundle),
		.fetch_pc(fetch_pc),
		.fetch_target(fetch_target),
		.fetch_pred(fetch_pred),
		.fetch_valid(fetch_valid),
		.mispredict(mispredict),
		.dec_word0(dec_word0),
		.dec_word1(dec_word1),
		.dec_word2(dec_word2),
		.dec_word3(dec_word3),
		.loop_state(loop_state),
		.loop_start(loop_start),
		.stall_fetch(stall_fetch)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// slot 0 sits in the top 16 bits
	function automatic pc_t slot_field(input pc_bundle_t v, input int s);
		return v[(3 - s)*16 +: 16];
	endfunction

	function automatic dec_word_t dut_word(input int s);
		case (s)
			0: return dec_word0;
			1: return dec_word1;
			2: return dec_word2;
			default: return dec_word3;
		endcase
	endfunction

	// expected decoded word from the opcode and operand rules
	function automatic dec_word_t ref_word(input inst_t inst, input pc_t pc, input pc_t tgt,
			input logic pred, input logic live);
		logic [3:0] op;
		unit_t u;
		alu_op_t a;
		logic use_rd;
		logic use_rs;
		logic use_rt;
		logic br;
		logic jp;
		logic pt;
		logic [15:0] imm;
		op = inst[15:12];
		if (!live || op == `OP_NOP || op > `OP_JMP)
			return '0;
		case (op)
			`OP_SUB, `OP_BEQ, `OP_BNE: a = `ALU_SUB;
			`OP_MUL: a = `ALU_MUL;
			`OP_AND: a = `ALU_AND;
			`OP_OR: a = `ALU_OR;
			`OP_LDI, `OP_JMP: a = `ALU_PASS;
			default: a = `ALU_ADD;
		endcase
		u = `UNIT_ADD;
		if (op == `OP_MUL)
			u = `UNIT_MULT;
		if (op == `OP_LD || op == `OP_ST)
			u = `UNIT_ADDR;
		// rd for add up to ld, rs for all but ldi and jmp
		use_rd = op <= `OP_LD;
		use_rs = op != `OP_LDI && op != `OP_JMP;
		use_rt = op <= `OP_OR || op == `OP_ST || op == `OP_BEQ || op == `OP_BNE;
		br = op == `OP_BEQ || op == `OP_BNE;
		jp = op == `OP_JMP;
		pt = br ? pred : jp;
		case (op)
			`OP_ADDI, `OP_LD: imm = {{12{inst[3]}}, inst[3:0]};
			`OP_LDI: imm = {{8{inst[7]}}, inst[7:0]};
			`OP_BEQ, `OP_BNE, `OP_JMP: imm = tgt;
			default: imm = 16'h0000;
		endcase
		return {1'b1, u, a, use_rd, op == `OP_LD, op == `OP_ST, br, jp, pt,
			use_rd ? inst[11:8] : 4'h0, use_rs ? inst[7:4] : 4'h0,
			use_rt ? inst[3:0] : 4'h0, imm};
	endfunction

	task automatic check_word(input string name, input dec_word_t expected,
			input dec_word_t actual);
		checks++;
		if (actual !== expected) begin
			word_errors++;
			$display("[ERROR] %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic check_state(input string name, input loop_state_t expected,
			input loop_state_t actual);
		checks++;
		if (actual !== expected) begin
			state_errors++;
			$display("[ERROR] %s expected %s actual %s", name, expected.name(), actual.name());
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		checks++;
		if (actual !== expected) begin
			bit_errors++;
			$display("[ERROR] %s expected %b actual %b", name, expected, actual);
		end
	endtask

	task automatic wait_fall(input string what);
		int edges;
		logic prev;
		edges = 0;
		// a fall counts only when it follows a high phase
		do begin
			prev = clk;
			@(clk);
			edges++;
		end while (!(prev === 1'b1 && clk === 1'b0) && edges < 4);
		if (!(prev === 1'b1 && clk === 1'b0)) begin
			$display("timeout: no falling clock edge arrived while %s", what);
			$display("Done: errors found");
			$finish;
		end
	endtask

	task automatic clear_slots();
		for (int s = 0; s < 4; s++) begin
			new_inst[s] = '0;
			new_pc[s] = '0;
			new_tgt[s] = '0;
		end
	endtask

	task automatic set_slot(input int s, input inst_t inst, input pc_t pc, input pc_t tgt);
		new_inst[s] = inst;
		new_pc[s] = pc;
		new_tgt[s] = tgt;
	endtask

	task automatic random_slots();
		for (int s = 0; s < 4; s++)
			set_slot(s, 16'($urandom), 16'($urandom), 16'($urandom));
	endtask

	task automatic push_row(input string name, input logic [3:0] pred, input logic valid,
			input logic mp);
		row_name.push_back(name);
		row_bundle.push_back({new_inst[0], new_inst[1], new_inst[2], new_inst[3]});
		row_pc.push_back({new_pc[0], new_pc[1], new_pc[2], new_pc[3]});
		row_target.push_back({new_tgt[0], new_tgt[1], new_tgt[2], new_tgt[3]});
		row_pred.push_back(pred);
		row_valid.push_back(valid);
		row_mp.push_back(mp);
	endtask

	task automatic build_table();
		// every opcode reaches every slot
		for (int r = 0; r < 16; r++) begin
			for (int s = 0; s < 4; s++)
				set_slot(s, {4'(r + s), 12'($urandom)}, 16'($urandom), 16'($urandom));
			push_row($sformatf("opcode_sweep_%0d", r), 4'($urandom), 1'b1, 1'b0);
		end
		for (int r = 0; r < 6; r++) begin
			random_slots();
			push_row($sformatf("bubble_%0d", r), 4'($urandom), r[0], 1'b0);
		end
		for (int r = 0; r < 12; r++) begin
			random_slots();
			push_row($sformatf("stream_%0d", r), 4'($urandom), 1'b1, 1'b0);
		end
		// loop detection starts from a clean tracker
		clear_slots();
		push_row("loop_clear", 4'b0000, 1'b1, 1'b1);
		push_row("loop_idle_0", 4'b0000, 1'b0, 1'b0);
		push_row("loop_idle_1", 4'b0000, 1'b0, 1'b0);
		set_slot(0, {`OP_ADD, 4'h1, 4'h2, 4'h3}, 16'h013e, 16'h0000);
		set_slot(1, {`OP_BEQ, 4'h0, 4'h3, 4'h4}, 16'h0140, 16'h0100);
		push_row("loop_first_seen", 4'b0100, 1'b1, 1'b0);
		clear_slots();
		set_slot(0, {`OP_BNE, 4'h0, 4'h5, 4'h6}, 16'h0200, 16'h0300);
		push_row("forward_branch", 4'b1000, 1'b1, 1'b0);
		set_slot(0, {`OP_BEQ, 4'h0, 4'h3, 4'h4}, 16'h0140, 16'h0100);
		push_row("not_predicted", 4'b0000, 1'b1, 1'b0);
		clear_slots();
		set_slot(3, {`OP_JMP, 12'h000}, 16'h0300, 16'h0080);
		push_row("new_target", 4'b0000, 1'b1, 1'b0);
		clear_slots();
		// slot 2 wins over slot 3
		set_slot(2, {`OP_BEQ, 4'h0, 4'h7, 4'h8}, 16'h0090, 16'h0080);
		set_slot(3, {`OP_BNE, 4'h0, 4'h9, 4'ha}, 16'h0050, 16'h0010);
		push_row("loop_second_seen", 4'b0011, 1'b1, 1'b0);
		clear_slots();
		set_slot(0, {`OP_BEQ, 4'h0, 4'h1, 4'h2}, 16'h0400, 16'h0100);
		push_row("locked_hold", 4'b1000, 1'b1, 1'b0);
		clear_slots();
		push_row("locked_idle_0", 4'b0000, 1'b0, 1'b0);
		push_row("locked_idle_1", 4'b0000, 1'b0, 1'b0);
		// flush with words in both steps
		random_slots();
		push_row("flush_shown", 4'b1111, 1'b1, 1'b0);
		random_slots();
		push_row("flush_in_step1", 4'b1111, 1'b1, 1'b0);
		random_slots();
		push_row("flush_row", 4'b1111, 1'b1, 1'b1);
		random_slots();
		push_row("after_flush", 4'($urandom), 1'b1, 1'b0);
		clear_slots();
		for (int r = 0; r < 3; r++)
			push_row($sformatf("drain_%0d", r), 4'b0000, 1'b0, 1'b0);
	endtask

	task automatic build_expected();
		int n;
		logic live;
		logic hit;
		logic start;
		pc_t hit_tgt;
		pc_t rec;
		pc_t pc;
		pc_t tgt;
		dec_word_t w;
		loop_state_t state;
		n = row_name.size();
		for (int k = 0; k < n; k++) begin
			// a flush drops its own row and the row still in step 1
			live = row_valid[k] && !row_mp[k] && !(k + 1 < n && row_mp[k + 1]);
			for (int s = 0; s < 4; s++)
				exp_word.push_back(ref_word(slot_field(row_bundle[k], s),
					slot_field(row_pc[k], s), slot_field(row_target[k], s),
					row_pred[k][3 - s], live));
		end
		state = LT_IDLE;
		rec = '0;
		for (int k = 0; k < n; k++) begin
			hit = 1'b0;
			hit_tgt = '0;
			start = 1'b0;
			// words of the row two bundles back reach the tracker now
			for (int s = 0; s < 4 && k >= 2; s++) begin
				w = exp_word[(k - 2)*4 + s];
				pc = slot_field(row_pc[k - 2], s);
				tgt = slot_field(row_target[k - 2], s);
				if (!hit && w[39] && w[28] && tgt <= pc) begin
					hit = 1'b1;
					hit_tgt = tgt;
				end
			end
			if (row_mp[k]) begin
				state = LT_IDLE;
			end else if (state == LT_IDLE && hit) begin
				state = LT_SEEN;
				rec = hit_tgt;
			end else if (state == LT_SEEN && hit) begin
				if (hit_tgt == rec) begin
					state = LT_LOCKED;
					start = 1'b1;
				end else begin
					rec = hit_tgt;
				end
			end
			exp_state.push_back(state);
			exp_start.push_back(start);
		end
	endtask

	initial begin
		int n;
		string name;
		reset = 1'b1;
		fetch_bundle = '0;
		fetch_pc = '0;
		fetch_target = '0;
		fetch_pred = '0;
		fetch_valid = 1'b0;
		mispredict = 1'b0;
		checks = 0;
		word_errors = 0;
		state_errors = 0;
		bit_errors = 0;
		void'($urandom(32'h5576));
		build_table();
		build_expected();
		n = row_name.size();
		for (int k = 0; k < 3; k++)
			wait_fall("holding reset");
		for (int s = 0; s < 4; s++)
			check_word($sformatf("after_reset slot %0d", s), '0, dut_word(s));
		check_state("after_reset state", LT_IDLE, loop_state);
		check_bit("after_reset loop_start", 1'b0, loop_start);
		check_bit("after_reset stall_fetch", 1'b0, stall_fetch);
		reset = 1'b0;
		for (int k = 0; k < n + 2; k++) begin
			if (k > 0)
				wait_fall("streaming bundles");
			if (k >= 2) begin
				for (int s = 0; s < 4; s++) begin
					name = $sformatf("%s slot %0d", row_name[k - 2], s);
					check_word(name, exp_word[(k - 2)*4 + s], dut_word(s));
				end
			end
			// tracker state after the previous rising edge
			if (k >= 1 && k <= n) begin
				name = row_name[k - 1];
				check_state({name, " state"}, exp_state[k - 1], loop_state);
				check_bit({name, " loop_start"}, exp_start[k - 1], loop_start);
				check_bit({name, " stall_fetch"}, exp_state[k - 1] == LT_LOCKED, stall_fetch);
			end
			if (k < n) begin
				fetch_bundle = row_bundle[k];
				fetch_pc = row_pc[k];
				fetch_target = row_target[k];
				fetch_pred = row_pred[k];
				fetch_valid = row_valid[k];
				mispredict = row_mp[k];
			end else begin
				fetch_valid = 1'b0;
				mispredict = 1'b0;
			end
		end
		$display("checks %0d, word errors %0d, state errors %0d, flag errors %0d",
			checks, word_errors, state_errors, bit_errors);
		if (word_errors + state_errors + bit_errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
+incdir+src
src/decode_pkg.sv
src/slot_ctrl_decode.sv
src/field_split_stage.sv
src/operand_format_stage.sv
src/loop_tracker.sv
src/decode_top.sv
bench/tb_decode_top.sv

/* run.sh */
#!/bin/sh
# compile the decode stage testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -f tb.f --top-module tb_decode_top -o sim_decode \
	&& ./obj_dir/sim_decode > sim.log 2>&1 \
	&& cat sim.log \
	&& ! grep -q "Done: errors found" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
